// File: backplane.f
+incdir+design
design/backplane_pkg.sv
design/grant_mux.sv
design/dma_arbiter.sv
design/io_decoder.sv
design/sdcard_dispatcher.sv
design/baud_select.sv
design/backplane_top.sv
tb/backplane_tb.sv

// File: Makefile
# Verilator build and run of the backplane testbench
TOP := backplane_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timescale 1ns/100ps -f backplane.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: tb/backplane_tb.sv
/*
 * backplane testbench, clock and reset, random and directed stimulus,
 * reference model of decode, merge, ownership, sd grant and divisors,
 * compare tasks, watchdog and final report
 */
`include "backplane_defines.svh"

module backplane_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 40;
   localparam int N_DEC  = 200;
   localparam int N_MRG  = 200;
   localparam int N_DMA  = 300;
   localparam int N_SD   = 300;
   localparam int N_BAUD = 16;
   localparam int TOTAL_CYCLES = 2 + N_DEC + N_MRG + 11 + N_DMA + N_SD + N_BAUD + 5;
   localparam int MARGIN = 50;   // slack for settle edges

   localparam logic [1:0] OWN_CPU = 2'd0;
   localparam logic [1:0] OWN_RK  = 2'd1;
   localparam logic [1:0] OWN_MY  = 2'd2;

   // windows to aim random addresses at
   localparam logic [15:0] IO_BASES [8] = '{`UART1_BASE, `UART2_BASE, `LPT_BASE, `RK_BASE,
                                           `DW_BASE, `RX_BASE, `MY_BASE, `KGD_BASE};
   localparam backplane_pkg::baud_div_t DIV_TABLE [8] = '{`BDIV_0, `BDIV_1, `BDIV_2, `BDIV_3,
                                                          `BDIV_4, `BDIV_5, `BDIV_6, `BDIV_7};

   logic                            wb_clk;
   logic                            rst_n_i;
   backplane_pkg::wb_req_t          cpu_req;
   backplane_pkg::wb_req_t          rk_req;
   backplane_pkg::wb_req_t          my_req;
   backplane_pkg::wb_rsp_t          cpu_rsp;
   backplane_pkg::wb_rsp_t          rk_rsp;
   backplane_pkg::wb_rsp_t          my_rsp;
   backplane_pkg::wb_req_t          bus_req;
   logic                            sysram_stb;
   backplane_pkg::dev_sel_t         dev_sel;
   backplane_pkg::dev_rsp_t         dev_rsp;
   logic [3:0]                      sd_req;
   backplane_pkg::sd_lines_t [3:0]  sd_lines;
   logic [3:0]                      sd_gnt;
   backplane_pkg::sd_lines_t        sdcard;
   logic                            console_sel;
   backplane_pkg::speed_t           term_speed;
   backplane_pkg::baud_div_t        uart1_bdiv;
   backplane_pkg::baud_div_t        uart2_bdiv;

   logic [1:0]  own_q;      // model bus owner
   logic [3:0]  sd_gnt_q;   // model sd grant
   logic        check_en;
   int          errors;
   int          checks;
   int          tests_run;

   backplane_top dut (
      .wb_clk (wb_clk), .rst_n_i (rst_n_i),
      .cpu_req_i (cpu_req), .rk_req_i (rk_req), .my_req_i (my_req),
      .cpu_rsp_o (cpu_rsp), .rk_rsp_o (rk_rsp), .my_rsp_o (my_rsp),
      .bus_req_o (bus_req), .sysram_stb_i (sysram_stb),
      .dev_sel_o (dev_sel), .dev_rsp_i (dev_rsp),
      .sd_req_i (sd_req), .sd_lines_i (sd_lines), .sd_gnt_o (sd_gnt), .sdcard_o (sdcard),
      .console_sel_i (console_sel), .term_speed_i (term_speed),
      .uart1_bdiv_o (uart1_bdiv), .uart2_bdiv_o (uart2_bdiv)
   );

   // ************************************************************
   // reference model
   // ************************************************************
   function automatic logic io_match(input logic [15:0] a, input logic [15:0] base,
                                     input int low);
      logic [15:0] mask;
      mask = 16'hffff << low;   // keep only the bits that select the window
      return (a & mask) == (base & mask);
   endfunction

   function automatic backplane_pkg::dev_sel_t ref_decode(input backplane_pkg::wb_req_t req,
                                                          input logic sysram);
      backplane_pkg::dev_sel_t s;
      logic act;
      act     = req.cyc & req.stb;
      s.uart1 = act & io_match(req.adr, `UART1_BASE, `UART1_LOW);
      s.uart2 = act & io_match(req.adr, `UART2_BASE, `UART2_LOW);
      s.lpt   = act & io_match(req.adr, `LPT_BASE, `LPT_LOW);
      s.rk    = act & io_match(req.adr, `RK_BASE, `RK_LOW);
      s.dw    = act & io_match(req.adr, `DW_BASE, `DW_LOW);
      s.rx    = act & io_match(req.adr, `RX_BASE, `RX_LOW);
      s.my    = act & io_match(req.adr, `MY_BASE, `MY_LOW);
      s.kgd   = act & io_match(req.adr, `KGD_BASE, `KGD_LOW);
      s.ram   = (act & (req.adr < 16'o160000)) | sysram;   // ram below the i/o region
      return s;
   endfunction

   // merged data of strobed slaves, ack from anyone
   function automatic backplane_pkg::wb_rsp_t ref_merge(input backplane_pkg::dev_sel_t s,
                                                        input backplane_pkg::dev_rsp_t r);
      backplane_pkg::wb_rsp_t m;
      m.dat = ({16{s.ram}} & r.ram.dat) | ({16{s.uart1}} & r.uart1.dat)
            | ({16{s.uart2}} & r.uart2.dat) | ({16{s.lpt}} & r.lpt.dat)
            | ({16{s.rk}} & r.rk.dat) | ({16{s.dw}} & r.dw.dat)
            | ({16{s.rx}} & r.rx.dat) | ({16{s.my}} & r.my.dat)
            | ({16{s.kgd}} & r.kgd.dat);
      m.ack = r.ram.ack | r.uart1.ack | r.uart2.ack | r.lpt.ack | r.rk.ack
            | r.dw.ack | r.rx.ack | r.my.ack | r.kgd.ack;
      return m;
   endfunction

   function automatic backplane_pkg::wb_req_t ref_bus_req(input logic [1:0] own,
      input backplane_pkg::wb_req_t cpu, input backplane_pkg::wb_req_t rk,
      input backplane_pkg::wb_req_t my);
      backplane_pkg::wb_req_t b;
      b = cpu;
      if (own == OWN_RK) begin
         b     = rk;
         b.sel = 2'b11;   // dma moves words
      end else if (own == OWN_MY) begin
         b     = my;
         b.sel = 2'b11;
      end
      return b;
   endfunction

   function automatic logic [1:0] next_owner(input logic [1:0] own,
      input backplane_pkg::wb_req_t cpu, input backplane_pkg::wb_req_t rk,
      input backplane_pkg::wb_req_t my);
      backplane_pkg::wb_req_t b;
      b = ref_bus_req(own, cpu, rk, my);
      if (b.cyc) return own;        // locked during a cycle
      if (rk.cyc) return OWN_RK;
      if (my.cyc) return OWN_MY;
      return OWN_CPU;
   endfunction

   function automatic logic [3:0] next_sd_gnt(input logic [3:0] gnt, input logic [3:0] req);
      if (gnt != 4'b0000) return gnt & req;   // hold till release
      if (req[0]) return 4'b0001;             // rk
      if (req[1]) return 4'b0010;             // dw
      if (req[2]) return 4'b0100;             // dx
      if (req[3]) return 4'b1000;             // my
      return 4'b0000;
   endfunction

   function automatic backplane_pkg::sd_lines_t ref_sd_route(input logic [3:0] gnt,
      input backplane_pkg::sd_lines_t [3:0] lines);
      backplane_pkg::sd_lines_t o;
      o.mosi = `SD_IDLE_MOSI;
      o.cs   = `SD_IDLE_CS;
      for (int i = 0; i < 4; i++) begin
         if (gnt[i]) o = lines[i];
      end
      return o;
   endfunction

   // divisor one port should see for the console setting
   function automatic backplane_pkg::baud_div_t ref_bdiv(input logic port2,
      input logic console, input backplane_pkg::speed_t speed);
      if (port2 == console) return DIV_TABLE[speed];   // port carries the console
      return DIV_TABLE[`UART2_SPEED];
   endfunction

   // ************************************************************
   // compare tasks
   // ************************************************************
   task automatic check_sel(input backplane_pkg::dev_sel_t got,
                            input backplane_pkg::dev_sel_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: dev_sel got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_rsp(input string what, input backplane_pkg::wb_rsp_t got,
                            input backplane_pkg::wb_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h/%b expected %h/%b", $time, what,
                  got.dat, got.ack, exp.dat, exp.ack);
      end
   endtask

   task automatic check_req(input backplane_pkg::wb_req_t got,
                            input backplane_pkg::wb_req_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: bus_req got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_gnt(input logic [3:0] got, input logic [3:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: sd_gnt got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_sd(input backplane_pkg::sd_lines_t got,
                           input backplane_pkg::sd_lines_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: sdcard got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_bdiv(input string what, input backplane_pkg::baud_div_t got,
                             input backplane_pkg::baud_div_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // ************************************************************
   // clock, model state, comparing process
   // ************************************************************
   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         own_q    <= OWN_CPU;
         sd_gnt_q <= 4'b0000;
      end else begin
         own_q    <= next_owner(own_q, cpu_req, rk_req, my_req);
         sd_gnt_q <= next_sd_gnt(sd_gnt_q, sd_req);
      end
   end

   // look just after the edge, once flops and model have moved
   always @(posedge wb_clk) begin
      backplane_pkg::wb_req_t   exp_bus;
      backplane_pkg::dev_sel_t  exp_sel;
      backplane_pkg::wb_rsp_t   exp_m;
      backplane_pkg::wb_rsp_t   exp_r;
      #1;
      if (check_en) begin
         exp_bus = ref_bus_req(own_q, cpu_req, rk_req, my_req);
         exp_sel = ref_decode(exp_bus, sysram_stb);
         exp_m   = ref_merge(exp_sel, dev_rsp);
         check_req(bus_req, exp_bus);
         check_sel(dev_sel, exp_sel);
         exp_r     = exp_m;
         exp_r.ack = exp_m.ack & (own_q == OWN_CPU);
         check_rsp("cpu_rsp", cpu_rsp, exp_r);
         exp_r.ack = exp_m.ack & (own_q == OWN_RK);
         check_rsp("rk_rsp", rk_rsp, exp_r);
         exp_r.ack = exp_m.ack & (own_q == OWN_MY);
         check_rsp("my_rsp", my_rsp, exp_r);
         check_gnt(sd_gnt, sd_gnt_q);
         check_sd(sdcard, ref_sd_route(sd_gnt_q, sd_lines));
         check_bdiv("uart1_bdiv", uart1_bdiv, ref_bdiv(1'b0, console_sel, term_speed));
         check_bdiv("uart2_bdiv", uart2_bdiv, ref_bdiv(1'b1, console_sel, term_speed));
      end
   end

   // ************************************************************
   // stimulus
   // ************************************************************
   function automatic backplane_pkg::wb_req_t rand_req();
      backplane_pkg::wb_req_t q;
      logic [31:0] r;
      r     = $urandom;
      q.adr = r[15:0];
      q.dat = r[31:16];
      r     = $urandom;
      q.cyc = r[0];
      q.we  = r[1];
      q.sel = r[3:2];
      q.stb = r[4];
      return q;
   endfunction

   function automatic backplane_pkg::dev_rsp_t rand_rsp();
      logic [159:0] r;
      r = {$urandom, $urandom, $urandom, $urandom, $urandom};
      return r[152:0];
   endfunction

   // random cpu cycles mostly aimed near the windows
   task automatic drive_cpu(input int cycles, input logic active);
      logic [31:0] r;
      for (int i = 0; i < cycles; i++) begin
         @(negedge wb_clk);
         r       = $urandom;
         cpu_req = rand_req();
         if (r[1:0] != 2'b00) cpu_req.adr = IO_BASES[r[4:2]] + {10'd0, r[10:5]};
         if (active) begin
            cpu_req.cyc = 1'b1;
            cpu_req.stb = 1'b1;
         end
         sysram_stb = (r[13:11] == 3'b000);
         dev_rsp    = rand_rsp();
      end
   endtask

   task automatic drive_dma(input int cycles);
      logic [31:0] r;
      // rk and my together with cpu idle, then my alone
      for (int i = 0; i < 11; i++) begin
         @(negedge wb_clk);
         cpu_req     = rand_req();
         rk_req      = rand_req();
         my_req      = rand_req();
         cpu_req.cyc = 1'b0;
         rk_req.cyc  = (i < 4);
         my_req.cyc  = (i < 4) || (i >= 6 && i < 9);
         dev_rsp     = rand_rsp();
      end
      for (int i = 0; i < cycles; i++) begin
         @(negedge wb_clk);
         r = $urandom;
         cpu_req = rand_req();
         cpu_req.cyc = (r[1:0] == 2'b00) ? ~bus_req.cyc : r[2];
         rk_req  = rand_req();
         rk_req.cyc = (r[4:3] == 2'b00) ? ~rk_req.cyc : r[5] & r[6];
         my_req  = rand_req();
         my_req.cyc = r[7] & r[8];
         dev_rsp = rand_rsp();
      end
      @(negedge wb_clk);
      rk_req.cyc = 1'b0;   // hand the bus back
      my_req.cyc = 1'b0;
   endtask

   task automatic drive_sd(input int cycles);
      logic [31:0] r;
      for (int i = 0; i < cycles; i++) begin
         @(negedge wb_clk);
         r = $urandom;
         for (int k = 0; k < 4; k++) begin
            if (r[2*k +: 2] == 2'b00) sd_req[k] = ~sd_req[k];   // runs of a few cycles
         end
         sd_lines = r[15:8];
      end
   endtask

   task automatic drive_baud();
      for (int s = 0; s < 8; s++) begin
         for (int c = 0; c < 2; c++) begin
            @(negedge wb_clk);
            term_speed  = s[2:0];
            console_sel = c[0];
         end
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      @(posedge wb_clk);
      #2;   // last check done
      tests_run++;
      if (errors == err_start) $display("test %s: ok", name);
      else $display("test %s: %0d mismatches", name, errors - err_start);
   endtask

   // ************************************************************
   // main sequence and watchdog
   // ************************************************************
   initial begin
      int e0;
      void'($urandom(94459));
      errors = 0;
      checks = 0;
      tests_run = 0;
      check_en = 1'b0;
      rst_n_i = 1'b0;
      cpu_req = '0;
      rk_req = '0;
      my_req = '0;
      sysram_stb = 1'b0;
      dev_rsp = '0;
      sd_req = 4'b0000;
      sd_lines = '1;
      console_sel = 1'b0;
      term_speed = 3'd0;
      repeat (2) @(posedge wb_clk);   // two rising edges under reset
      @(negedge wb_clk);
      rst_n_i  = 1'b1;
      check_en = 1'b1;
      e0 = errors;
      drive_cpu(N_DEC, 1'b0);
      report_test("decode", e0);
      e0 = errors;
      drive_cpu(N_MRG, 1'b1);
      report_test("merge", e0);
      e0 = errors;
      drive_dma(N_DMA);
      report_test("dma", e0);
      e0 = errors;
      drive_sd(N_SD);
      report_test("sd", e0);
      e0 = errors;
      drive_baud();
      report_test("baud", e0);
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
      $display("timeout: the tests did not finish in %0d cycles", TOTAL_CYCLES + MARGIN);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: design/backplane_top.sv
/*
 * backplane top, dma arbiter, i/o page decoder,
 * sd card dispatcher and baud select wired together
 */
module backplane_top (
   input  logic                             wb_clk,
   input  logic                             rst_n_i,

   // masters
   input  backplane_pkg::wb_req_t           cpu_req_i,
   input  backplane_pkg::wb_req_t           rk_req_i,
   input  backplane_pkg::wb_req_t           my_req_i,
   output backplane_pkg::wb_rsp_t           cpu_rsp_o,
   output backplane_pkg::wb_rsp_t           rk_rsp_o,
   output backplane_pkg::wb_rsp_t           my_rsp_o,

   // slaves
   output backplane_pkg::wb_req_t           bus_req_o,
   input  logic                             sysram_stb_i,
   output backplane_pkg::dev_sel_t          dev_sel_o,
   input  backplane_pkg::dev_rsp_t          dev_rsp_i,

   // sd card
   input  logic [3:0]                       sd_req_i,
   input  backplane_pkg::sd_lines_t [3:0]   sd_lines_i,
   output logic [3:0]                       sd_gnt_o,
   output backplane_pkg::sd_lines_t         sdcard_o,

   // serial ports
   input  logic                             console_sel_i,
   input  backplane_pkg::speed_t            term_speed_i,
   output backplane_pkg::baud_div_t         uart1_bdiv_o,
   output backplane_pkg::baud_div_t         uart2_bdiv_o
);

   logic [15:0] rd_dat;    // merged slave read data
   logic        bus_ack;   // ored slave acks

   // ************************************************************
   // bus masters
   // ************************************************************
   dma_arbiter u_dma_arbiter (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .cpu_req_i (cpu_req_i),
      .rk_req_i  (rk_req_i),
      .my_req_i  (my_req_i),
      .bus_ack_i (bus_ack),
      .rd_dat_i  (rd_dat),
      .bus_req_o (bus_req_o),
      .cpu_rsp_o (cpu_rsp_o),
      .rk_rsp_o  (rk_rsp_o),
      .my_rsp_o  (my_rsp_o)
   );

   // ************************************************************
   // slave decode
   // ************************************************************
   io_decoder u_io_decoder (
      .bus_req_i    (bus_req_o),
      .sysram_stb_i (sysram_stb_i),
      .dev_rsp_i    (dev_rsp_i),
      .dev_sel_o    (dev_sel_o),
      .rd_dat_o     (rd_dat),
      .bus_ack_o    (bus_ack)
   );

   // ************************************************************
   // sd card and uart speeds
   // ************************************************************
   sdcard_dispatcher u_sdcard_dispatcher (
      .wb_clk     (wb_clk),
      .rst_n_i    (rst_n_i),
      .sd_req_i   (sd_req_i),
      .sd_lines_i (sd_lines_i),
      .sd_gnt_o   (sd_gnt_o),
      .sdcard_o   (sdcard_o)
   );

   baud_select u_baud_select (
      .console_sel_i (console_sel_i),
      .term_speed_i  (term_speed_i),
      .uart1_bdiv_o  (uart1_bdiv_o),
      .uart2_bdiv_o  (uart2_bdiv_o)
   );

endmodule

// File: design/baud_select.sv
/*
 * uart divisor lookup for the terminal speed and the fixed
 * second port speed, console port swap
 */
`include "backplane_defines.svh"

module baud_select (
   input  logic                       console_sel_i,  // 1 = ports swapped
   input  backplane_pkg::speed_t      term_speed_i,
   output backplane_pkg::baud_div_t   uart1_bdiv_o,
   output backplane_pkg::baud_div_t   uart2_bdiv_o
);

   backplane_pkg::baud_div_t term_div;   // follows the terminal
   backplane_pkg::baud_div_t fixed_div;  // second port, constant

   function automatic backplane_pkg::baud_div_t div_of(input backplane_pkg::speed_t s);
      case (s)
         3'd0:    return `BDIV_0;   // 1200
         3'd1:    return `BDIV_1;   // 2400
         3'd2:    return `BDIV_2;   // 4800
         3'd3:    return `BDIV_3;   // 9600
         3'd4:    return `BDIV_4;   // 19200
         3'd5:    return `BDIV_5;   // 38400
         3'd6:    return `BDIV_6;   // 57600
         default: return `BDIV_7;   // 115200
      endcase
   endfunction

   assign term_div  = div_of(term_speed_i);
   assign fixed_div = div_of(`UART2_SPEED);

   // console on uart1 unless swapped
   assign uart1_bdiv_o = console_sel_i ? fixed_div : term_div;
   assign uart2_bdiv_o = console_sel_i ? term_div : fixed_div;

endmodule

// File: design/sdcard_dispatcher.sv
/*
 * sd card sharing between rk, dw, dx and my controllers,
 * hold-until-release priority grant and card line routing
 */
`include "backplane_defines.svh"

module sdcard_dispatcher (
   input  logic                             wb_clk,
   input  logic                             rst_n_i,
   input  logic [3:0]                       sd_req_i,     // indexed by sd_ctl_t
   input  backplane_pkg::sd_lines_t [3:0]   sd_lines_i,
   output logic [3:0]                       sd_gnt_o,
   output backplane_pkg::sd_lines_t         sdcard_o
);

   localparam backplane_pkg::sd_lines_t SD_IDLE = '{mosi: `SD_IDLE_MOSI, cs: `SD_IDLE_CS};

   logic [3:0]                gnt_q;
   backplane_pkg::sd_lines_t  lines_a [4];

   // ************************************************************
   // grant state
   // ************************************************************
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_q <= '0;
      end else if (gnt_q == '0) begin
         // card free, pick by priority
         if (sd_req_i[backplane_pkg::SD_RK]) begin
            gnt_q[backplane_pkg::SD_RK] <= 1'b1;
         end else if (sd_req_i[backplane_pkg::SD_DW]) begin
            gnt_q[backplane_pkg::SD_DW] <= 1'b1;
         end else if (sd_req_i[backplane_pkg::SD_DX]) begin
            gnt_q[backplane_pkg::SD_DX] <= 1'b1;
         end else if (sd_req_i[backplane_pkg::SD_MY]) begin
            gnt_q[backplane_pkg::SD_MY] <= 1'b1;
         end
      end else begin
         gnt_q <= gnt_q & sd_req_i;   // held until the owner lets go
      end
   end

   assign sd_gnt_o = gnt_q;

   // line routing
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lines_a[i] = sd_lines_i[i];
      end
   end

   grant_mux #(
      .T    (backplane_pkg::sd_lines_t),
      .N    (4),
      .IDLE (SD_IDLE)
   ) u_line_mux (
      .sel_i  (gnt_q),
      .data_i (lines_a),
      .data_o (sdcard_o)
   );

   a_gnt_onehot : assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot0(sd_gnt_o))
      else $error("sdcard_dispatcher: grants %b", sd_gnt_o);

   // no grant is taken away from a controller still asking
   for (genvar i = 0; i < 4; i++) begin : g_hold
      a_gnt_hold : assert property (@(posedge wb_clk) disable iff (!rst_n_i)
         sd_gnt_o[i] && sd_req_i[i] |=> sd_gnt_o[i])
         else $error("sdcard_dispatcher: grant %0d dropped under request", i);
   end

endmodule

// File: design/io_decoder.sv
/*
 * i/o page and ram address decode, one strobe per slave,
 * read data merge under the strobes, ack or
 */
`include "backplane_defines.svh"

module io_decoder (
   input  backplane_pkg::wb_req_t   bus_req_i,
   input  logic                     sysram_stb_i,  // cpu board service ram
   input  backplane_pkg::dev_rsp_t  dev_rsp_i,
   output backplane_pkg::dev_sel_t  dev_sel_o,
   output logic [15:0]              rd_dat_o,
   output logic                     bus_ack_o
);

   logic                            bus_act;   // stb and cyc both up
   logic [15:0]                     adr;
   logic [8:0]                      sel_v;     // strobes as a vector, ram at 8
   backplane_pkg::wb_rsp_t [8:0]    rsp_v;     // answers, same order

   // address matches base once the register bits are dropped
   function automatic logic io_hit(input logic [15:0] a, input logic [15:0] base,
                                   input int unsigned low);
      return (a >> low) == (base >> low);
   endfunction

   assign bus_act = bus_req_i.stb & bus_req_i.cyc;
   assign adr     = bus_req_i.adr;

   // ************************************************************
   // slave strobes
   // ************************************************************
   assign dev_sel_o.uart1 = bus_act & io_hit(adr, `UART1_BASE, `UART1_LOW); // 177560-177566
   assign dev_sel_o.uart2 = bus_act & io_hit(adr, `UART2_BASE, `UART2_LOW); // 176500-176506
   assign dev_sel_o.lpt   = bus_act & io_hit(adr, `LPT_BASE, `LPT_LOW);     // 177514-177516
   assign dev_sel_o.rk    = bus_act & io_hit(adr, `RK_BASE, `RK_LOW);       // 177400-177416
   assign dev_sel_o.dw    = bus_act & io_hit(adr, `DW_BASE, `DW_LOW);       // 174000-174036
   assign dev_sel_o.rx    = bus_act & io_hit(adr, `RX_BASE, `RX_LOW);       // 177170-177172
   assign dev_sel_o.my    = bus_act & io_hit(adr, `MY_BASE, `MY_LOW);       // 172140-172142
   assign dev_sel_o.kgd   = bus_act & io_hit(adr, `KGD_BASE, `KGD_LOW);     // 176640-176646

   // ram 000000 to 157777 plus whatever the cpu board claims
   assign dev_sel_o.ram = (bus_act & (adr[15:13] != `RAM_TOP_BITS)) | sysram_stb_i;

   // ************************************************************
   // read data and ack
   // ************************************************************
   assign sel_v = dev_sel_o;
   assign rsp_v = dev_rsp_i;

   always_comb begin
      rd_dat_o  = '0;
      bus_ack_o = 1'b0;
      for (int i = 0; i < 9; i++) begin
         if (sel_v[i]) begin
            rd_dat_o = rd_dat_o | rsp_v[i].dat;   // only strobed slaves drive
         end
         bus_ack_o = bus_ack_o | rsp_v[i].ack;    // any ack counts
      end
   end

   // i/o page windows must not overlap
   always_comb begin
      assert final ($onehot0(sel_v[7:0]))
         else $error("io_decoder: strobes %b overlap at %o", sel_v[7:0], adr);
   end

endmodule

// File: design/dma_arbiter.sv
/*
 * bus ownership between cpu, rk11 dma and my dma,
 * shared bus request and per-master responses
 */
module dma_arbiter (
   input  logic                    wb_clk,
   input  logic                    rst_n_i,
   input  backplane_pkg::wb_req_t  cpu_req_i,
   input  backplane_pkg::wb_req_t  rk_req_i,
   input  backplane_pkg::wb_req_t  my_req_i,
   input  logic                    bus_ack_i,   // ored slave acks
   input  logic [15:0]             rd_dat_i,    // merged read data
   output backplane_pkg::wb_req_t  bus_req_o,
   output backplane_pkg::wb_rsp_t  cpu_rsp_o,
   output backplane_pkg::wb_rsp_t  rk_rsp_o,
   output backplane_pkg::wb_rsp_t  my_rsp_o
);

   logic rk_own;   // rk11 holds the bus
   logic my_own;   // my holds the bus
   logic cpu_own;

   backplane_pkg::wb_req_t req_a [3];   // cpu, rk, my

   assign cpu_own = ~(rk_own | my_own);

   // ************************************************************
   // ownership re-chosen only between bus cycles
   // ************************************************************
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rk_own <= 1'b0;
         my_own <= 1'b0;
      end else if (!bus_req_o.cyc) begin
         rk_own <= rk_req_i.cyc;                  // rk first
         my_own <= ~rk_req_i.cyc & my_req_i.cyc;  // then my, else cpu
      end
   end

   // dma masters always move whole words
   always_comb begin
      req_a[0]     = cpu_req_i;
      req_a[1]     = rk_req_i;
      req_a[1].sel = 2'b11;
      req_a[2]     = my_req_i;
      req_a[2].sel = 2'b11;
   end

   grant_mux #(
      .T (backplane_pkg::wb_req_t),
      .N (3)
   ) u_req_mux (
      .sel_i  ({my_own, rk_own, cpu_own}),
      .data_i (req_a),
      .data_o (bus_req_o)
   );

   // read data goes to everyone, ack only to the owner
   assign cpu_rsp_o.dat = rd_dat_i;
   assign cpu_rsp_o.ack = bus_ack_i & cpu_own;
   assign rk_rsp_o.dat  = rd_dat_i;
   assign rk_rsp_o.ack  = bus_ack_i & rk_own;
   assign my_rsp_o.dat  = rd_dat_i;
   assign my_rsp_o.ack  = bus_ack_i & my_own;

   // a running bus cycle keeps its master
   a_own_stable : assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      bus_req_o.cyc |=> $stable({rk_own, my_own}))
      else $error("dma_arbiter: owner changed inside a bus cycle");

endmodule

// File: design/grant_mux.sv
/*
 * one-hot select of one payload out of N, idle value when nothing
 * is selected; payload type is a parameter
 */
module grant_mux #(
   parameter type T    = logic,
   parameter int  N    = 2,
   parameter T    IDLE = T'('0)     // output with no select bit set
) (
   input  logic [N-1:0] sel_i,     // one-hot or zero
   input  T             data_i [N],
   output T             data_o
);

   always_comb begin
      data_o = IDLE;
      for (int i = 0; i < N; i++) begin
         if (sel_i[i]) begin
            data_o = data_i[i];   // at most one hit
         end
      end
   end

   // settled select must never carry two grants
   always_comb begin
      assert final ($onehot0(sel_i))
         else $error("grant_mux: select %b is not one-hot", sel_i);
   end

endmodule

// File: design/backplane_pkg.sv
/*
 * bus request and response types, slave strobe and slave response
 * bundles, sd card line type, controller index, baud types
 */
package backplane_pkg;

   // one master's request onto the wishbone bus
   typedef struct packed {
      logic [15:0] adr;    // byte address
      logic [15:0] dat;    // write data
      logic        cyc;
      logic        we;     // 1 = write
      logic [1:0]  sel;    // byte lanes
      logic        stb;
   } wb_req_t;

   // answer back to a master or from a slave
   typedef struct packed {
      logic [15:0] dat;
      logic        ack;
   } wb_rsp_t;

   // one strobe per slave, ram in the msb
   typedef struct packed {
      logic ram;
      logic uart1;
      logic uart2;
      logic lpt;
      logic rk;
      logic dw;
      logic rx;
      logic my;
      logic kgd;
   } dev_sel_t;

   // slave answers, same order as dev_sel_t
   typedef struct packed {
      wb_rsp_t ram;
      wb_rsp_t uart1;
      wb_rsp_t uart2;
      wb_rsp_t lpt;
      wb_rsp_t rk;
      wb_rsp_t dw;
      wb_rsp_t rx;
      wb_rsp_t my;
      wb_rsp_t kgd;
   } dev_rsp_t;

   typedef struct packed {
      logic mosi;
      logic cs;
   } sd_lines_t;

   // disk controllers sharing the card in sd grant priority order
   typedef enum logic [1:0] {SD_RK, SD_DW, SD_DX, SD_MY} sd_ctl_t;

   typedef logic [31:0] baud_div_t;   // uart divisor
   typedef logic [2:0]  speed_t;      // 0 = 1200 .. 7 = 115200

endpackage

// File: design/backplane_defines.svh
/*
 * I/O page base addresses and match widths, RAM region top bits,
 * UART divisor table, fixed second port speed, SD card idle levels
 */
`ifndef BACKPLANE_DEFINES_SVH
`define BACKPLANE_DEFINES_SVH

// ************************************************************
// I/O page bases (octal) and low address bits ignored in match
// ************************************************************
`define UART1_BASE    16'o177560  // console port
`define UART1_LOW     3
`define UART2_BASE    16'o176500  // second serial port
`define UART2_LOW     3
`define LPT_BASE      16'o177514  // printer
`define LPT_LOW       2
`define RK_BASE       16'o177400  // rk11 disk
`define RK_LOW        4
`define DW_BASE       16'o174000  // dw hard disk
`define DW_LOW        5
`define RX_BASE       16'o177170  // rx01 floppy
`define RX_LOW        2
`define MY_BASE       16'o172140  // my floppy
`define MY_LOW        2
`define KGD_BASE      16'o176640  // graphics
`define KGD_LOW       3

// ram is everything below 160000
`define RAM_TOP_BITS  3'b111

// ************************************************************
// uart divisors by speed index from 1200 up to 115200 baud
// ************************************************************
`define BDIV_0        32'd767
`define BDIV_1        32'd383
`define BDIV_2        32'd191
`define BDIV_3        32'd95
`define BDIV_4        32'd47
`define BDIV_5        32'd23
`define BDIV_6        32'd15
`define BDIV_7        32'd7
`define UART2_SPEED   3'd3        // 9600 baud

// card lines when nobody holds the card
`define SD_IDLE_MOSI  1'b1
`define SD_IDLE_CS    1'b1

`endif
